// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= clock_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP OBJ_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+verilog
verilog/clock_pkg.sv
verilog/button_sync.sv
verilog/mode_ctrl.sv
verilog/time_counter.sv
verilog/date_counter.sv
verilog/clock_top.sv
sim/clock_chk.sv
sim/clock_tb.sv

// ==== sim/clock_chk.sv ====
`timescale 1ns/1ps
`include "clock_defines.svh"

module clock_chk (
	input logic                   clk_1Hz,
	input logic                   rst_n,
	input clock_pkg::clock_mode_t mode,
	input clock_pkg::sec_t        seconds,
	input clock_pkg::min_t        minutes,
	input clock_pkg::hour_t       hours,
	input clock_pkg::day_t        days,
	input clock_pkg::month_t      months,
	input clock_pkg::year_t       years
);

	import clock_pkg::*;

	// Longest day the given month allows
	function automatic day_t max_day(input month_t m, input year_t y);
		day_t len;
		len = 5'd31;
		if (m == 4'd4 || m == 4'd6 || m == 4'd9 || m == 4'd11) begin
			len = 5'd30;
		end
		if (m == 4'd2) begin
			len = (y[1:0] == 2'b00) ? 5'd29 : 5'd28;
		end
		return len;
	endfunction

	// **************************************************
	// Field ranges
	// **************************************************

	a_time_range: assert property (@(posedge clk_1Hz) disable iff (!rst_n)
		seconds <= `CLK_SEC_MAX && minutes <= `CLK_MIN_MAX && hours <= `CLK_HOUR_MAX)
		else $error("time field out of range");

	a_date_range: assert property (@(posedge clk_1Hz) disable iff (!rst_n)
		months >= 4'd1 && months <= `CLK_MONTH_MAX && years <= `CLK_YEAR_MAX)
		else $error("month or year out of range");

	// Day stays within the length of the current month
	a_day_range: assert property (@(posedge clk_1Hz) disable iff (!rst_n)
		days != 5'd0 && days <= max_day(months, years))
		else $error("day out of range");

	// **************************************************
	// Hold and carry
	// **************************************************

	// Minute setting may clear seconds
	a_sec_hold: assert property (@(posedge clk_1Hz) disable iff (!rst_n)
		($past(mode) != RUN && $past(mode) != SET_MIN) |-> $stable(seconds))
		else $error("seconds moved while held");

	a_date_carry: assert property (@(posedge clk_1Hz) disable iff (!rst_n)
		(($past(mode) == RUN || $past(mode) == SET_HOUR || $past(mode) == SET_MIN)
		&& !$stable({days, months, years}))
		|-> $past(seconds == 6'd59 && minutes == 6'd59 && hours == 5'd23))
		else $error("date changed away from midnight");

endmodule

bind clock_top clock_chk u_clock_chk (.*);

// ==== sim/clock_tb.sv ====
`timescale 1ns/1ps
`include "clock_defines.svh"

module clock_tb;

	import clock_pkg::*;

	localparam int CYCLE_LIMIT = 20000;

	typedef struct packed {
		sec_t   s;
		min_t   m;
		hour_t  h;
		day_t   d;
		month_t mo;
		year_t  y;
	} cal_t;

	logic        clk_1Hz;
	logic        rst_n;
	logic        set_btn_n;
	logic        mode_btn_n;
	clock_mode_t mode;
	sec_t        seconds;
	min_t        minutes;
	hour_t       hours;
	day_t        days;
	month_t      months;
	year_t       years;

	cal_t        ref_cal;
	clock_mode_t ref_mode;
	logic [3:0]  set_pipe;
	logic [3:0]  mode_pipe;
	logic        last_set;
	logic        last_mode;
	logic        checking;
	logic [31:0] rng;
	int          cycle_count;

	clock_top UUT (
		.clk_1Hz    (clk_1Hz),
		.rst_n      (rst_n),
		.set_btn_n  (set_btn_n),
		.mode_btn_n (mode_btn_n),
		.mode       (mode),
		.seconds    (seconds),
		.minutes    (minutes),
		.hours      (hours),
		.days       (days),
		.months     (months),
		.years      (years)
	);

	initial begin
		clk_1Hz = 1'b0;
	end

	always #4 clk_1Hz = ~clk_1Hz;

	// **************************************************
	// Reference model
	// **************************************************

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic day_t days_in_month(input month_t m, input year_t y);
		if (m == 4'd2) begin
			return ((y % 7'd4) == 7'd0) ? 5'd29 : 5'd28;
		end
		if (m == 4'd4 || m == 4'd6 || m == 4'd9 || m == 4'd11) begin
			return 5'd30;
		end
		return 5'd31;
	endfunction

	function automatic clock_mode_t mode_after(input clock_mode_t md);
		if (md == SET_YEAR) begin
			return RUN;
		end
		return clock_mode_t'(md + 3'd1);
	endfunction

	function automatic cal_t ref_next(input cal_t c, input clock_mode_t md, input logic hit);
		cal_t n;
		logic midnight;
		n = c;
		midnight = (md == RUN) && (c.s == `CLK_SEC_MAX) && (c.m == `CLK_MIN_MAX)
			&& (c.h == `CLK_HOUR_MAX);
		case (md)
			RUN: begin
				if (c.s == `CLK_SEC_MAX) begin
					n.s = 6'd0;
					n.m = (c.m == `CLK_MIN_MAX) ? 6'd0 : c.m + 6'd1;
					if (c.m == `CLK_MIN_MAX) begin
						n.h = (c.h == `CLK_HOUR_MAX) ? 5'd0 : c.h + 5'd1;
					end
				end else begin
					n.s = c.s + 6'd1;
				end
			end
			SET_HOUR: begin
				if (hit) begin
					n.h = (c.h == `CLK_HOUR_MAX) ? 5'd0 : c.h + 5'd1;
				end
			end
			SET_MIN: begin
				if (hit) begin
					n.m = (c.m == `CLK_MIN_MAX) ? 6'd0 : c.m + 6'd1;
					n.s = 6'd0;
				end
			end
			SET_DAY: begin
				if (hit) begin
					n.d = (c.d >= days_in_month(c.mo, c.y)) ? 5'd1 : c.d + 5'd1;
				end
			end
			SET_MONTH: begin
				if (hit) begin
					n.mo = (c.mo == `CLK_MONTH_MAX) ? 4'd1 : c.mo + 4'd1;
					if (n.d > days_in_month(n.mo, c.y)) begin
						n.d = days_in_month(n.mo, c.y);
					end
				end
			end
			default: begin
				if (hit) begin
					n.y = (c.y == `CLK_YEAR_MAX) ? 7'd0 : c.y + 7'd1;
					if (n.d > days_in_month(c.mo, n.y)) begin
						n.d = days_in_month(c.mo, n.y);
					end
				end
			end
		endcase
		if (midnight) begin
			if (c.d == days_in_month(c.mo, c.y)) begin
				n.d = 5'd1;
				n.mo = (c.mo == `CLK_MONTH_MAX) ? 4'd1 : c.mo + 4'd1;
				if (c.mo == `CLK_MONTH_MAX) begin
					n.y = (c.y == `CLK_YEAR_MAX) ? 7'd0 : c.y + 7'd1;
				end
			end else begin
				n.d = c.d + 5'd1;
			end
		end
		return n;
	endfunction

	function automatic int field_value(input clock_mode_t md);
		case (md)
			SET_HOUR:  return int'(ref_cal.h);
			SET_MIN:   return int'(ref_cal.m);
			SET_DAY:   return int'(ref_cal.d);
			SET_MONTH: return int'(ref_cal.mo);
			default:   return int'(ref_cal.y);
		endcase
	endfunction

	// **************************************************
	// Compare tasks
	// **************************************************

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_mode(input clock_mode_t exp, input clock_mode_t act);
		if (exp != act) begin
			$display("ERR %0t mode exp %0d act %0d", $time, exp, act);
			report_failure("mode mismatch");
		end
	endtask

	task automatic check_time(input sec_t es, input min_t em, input hour_t eh,
		input sec_t as, input min_t am, input hour_t ah);
		if (es != as) begin
			$display("ERR %0t seconds exp %0d act %0d", $time, es, as);
			report_failure("time mismatch");
		end
		if (em != am) begin
			$display("ERR %0t minutes exp %0d act %0d", $time, em, am);
			report_failure("time mismatch");
		end
		if (eh != ah) begin
			$display("ERR %0t hours exp %0d act %0d", $time, eh, ah);
			report_failure("time mismatch");
		end
	endtask

	task automatic check_date(input day_t ed, input month_t em, input year_t ey,
		input day_t ad, input month_t am, input year_t ay);
		if (ed != ad) begin
			$display("ERR %0t days exp %0d act %0d", $time, ed, ad);
			report_failure("date mismatch");
		end
		if (em != am) begin
			$display("ERR %0t months exp %0d act %0d", $time, em, am);
			report_failure("date mismatch");
		end
		if (ey != ay) begin
			$display("ERR %0t years exp %0d act %0d", $time, ey, ay);
			report_failure("date mismatch");
		end
	endtask

	// Outputs are settled at the falling edge
	always @(negedge clk_1Hz) begin
		if (checking) begin
			check_mode(ref_mode, mode);
			check_time(ref_cal.s, ref_cal.m, ref_cal.h, seconds, minutes, hours);
			check_date(ref_cal.d, ref_cal.mo, ref_cal.y, days, months, years);
		end
	end

	always @(posedge clk_1Hz) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Run took too many cycles and was stopped");
			$display("Test failed");
			$fatal(1);
		end
	end

	// **************************************************
	// Stimulus
	// **************************************************

	// A falling button level takes effect on the fourth edge after it is driven
	task automatic drive_cycle(input logic set_lvl, input logic mode_lvl);
		logic set_hit;
		logic mode_hit;
		@(posedge clk_1Hz);
		set_btn_n  <= set_lvl;
		mode_btn_n <= mode_lvl;
		set_hit   = set_pipe[3];
		mode_hit  = mode_pipe[3];
		set_pipe  = {set_pipe[2:0], last_set & ~set_lvl};
		mode_pipe = {mode_pipe[2:0], last_mode & ~mode_lvl};
		last_set  = set_lvl;
		last_mode = mode_lvl;
		ref_cal = ref_next(ref_cal, ref_mode, set_hit);
		if (mode_hit) begin
			ref_mode = mode_after(ref_mode);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) drive_cycle(1'b1, 1'b1);
	endtask

	task automatic hold_set(input int n);
		repeat (n) drive_cycle(1'b0, 1'b1);
		drive_cycle(1'b1, 1'b1);
		idle(4);
	endtask

	task automatic press_mode();
		repeat (2) drive_cycle(1'b1, 1'b0);
		drive_cycle(1'b1, 1'b1);
		idle(4);
	endtask

	task automatic goto_mode(input clock_mode_t md);
		while (ref_mode != md) begin
			press_mode();
		end
	endtask

	task automatic set_field(input clock_mode_t md, input int target);
		int guard;
		guard = 0;
		goto_mode(md);
		while (field_value(md) != target) begin
			if (guard > 120) begin
				report_failure("field never reached its target value");
			end
			hold_set(2);
			guard++;
		end
	endtask

	task automatic set_date(input int d, input int m, input int y);
		set_field(SET_YEAR, y);
		set_field(SET_MONTH, m);
		set_field(SET_DAY, d);
	endtask

	task automatic midnight_run(input int d, input int m, input int y);
		set_date(d, m, y);
		set_field(SET_HOUR, 23);
		set_field(SET_MIN, 59);
		goto_mode(RUN);
		idle(66);
	endtask

	initial begin
		int n;
		int m;
		int y;
		rst_n      <= 1'b0;
		set_btn_n  <= 1'b1;
		mode_btn_n <= 1'b1;
		ref_cal     = '{s: 6'd0, m: 6'd0, h: 5'd0, d: 5'd1, mo: 4'd1, y: 7'd0};
		ref_mode    = RUN;
		set_pipe    = 4'd0;
		mode_pipe   = 4'd0;
		last_set    = 1'b1;
		last_mode   = 1'b1;
		checking    = 1'b0;
		cycle_count = 0;
		rng         = 32'h2c21_770a;
		repeat (3) @(posedge clk_1Hz);
		rst_n <= 1'b1;
		checking = 1'b1;

		// Free running after reset
		idle(130);

		// Walk all six modes
		repeat (6) begin
			press_mode();
			idle(3);
		end

		// Random time setting past the wrap, then a forced hour carry
		rng = xorshift(rng);
		n = 24 + int'(rng % 32'd6);
		goto_mode(SET_HOUR);
		repeat (n) hold_set(2);
		rng = xorshift(rng);
		n = 60 + int'(rng % 32'd10);
		goto_mode(SET_MIN);
		repeat (n) hold_set(2);
		set_field(SET_MIN, 59);
		goto_mode(RUN);
		idle(70);

		// Day presses wrap at the month length
		rng = xorshift(rng);
		n = 31 + int'(rng % 32'd9);
		goto_mode(SET_DAY);
		repeat (n) hold_set(2);

		// Random target dates
		repeat (3) begin
			rng = xorshift(rng);
			m = 1 + int'(rng % 32'd12);
			rng = xorshift(rng);
			y = int'(rng % 32'd100);
			rng = xorshift(rng);
			n = 1 + int'(rng % 32'(days_in_month(month_t'(m), year_t'(y))));
			set_date(n, m, y);
		end

		// Month and year clamps
		rng = xorshift(rng);
		set_date(31, 1, int'(rng % 32'd100));
		goto_mode(SET_MONTH);
		hold_set(2);
		set_date(29, 2, 24);
		goto_mode(SET_YEAR);
		hold_set(2);

		// Midnight carries
		midnight_run(30, 4, 57);
		midnight_run(28, 2, 23);
		midnight_run(29, 2, 24);
		midnight_run(31, 12, 99);

		// Long hold counts once
		goto_mode(SET_HOUR);
		hold_set(20);
		goto_mode(RUN);
		idle(5);

		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== verilog/button_sync.sv ====
`timescale 1ns/1ps
`include "clock_defines.svh"

module button_sync (
	input  logic clk_1Hz,
	input  logic rst_n,
	input  logic set_btn_n,
	input  logic mode_btn_n,
	output logic set_press,
	output logic mode_press
);

	localparam int STAGES = `CLK_SYNC_STAGES;

	logic [1:0] btn_n;
	logic [1:0] press;

	// Bit 0 is the set button, bit 1 the mode button
	assign btn_n = {mode_btn_n, set_btn_n};

	for (genvar i = 0; i < 2; i++) begin : g_btn
		logic [STAGES-1:0] sync_q;
		logic              level_last;

		// Released level is high, so the chain resets to ones
		always_ff @(posedge clk_1Hz or negedge rst_n) begin
			if (!rst_n) begin
				sync_q     <= '1;
				level_last <= 1'b1;
				press[i]   <= 1'b0;
			end else begin
				sync_q     <= {sync_q[STAGES-2:0], btn_n[i]};
				level_last <= sync_q[STAGES-1];
				// One pulse per falling edge of the synchronized level
				press[i]   <= level_last & ~sync_q[STAGES-1];
			end
		end
	end

	assign set_press  = press[0];
	assign mode_press = press[1];

endmodule

// ==== verilog/clock_defines.svh ====
`ifndef CLOCK_DEFINES_SVH
`define CLOCK_DEFINES_SVH

// **************************************************
// Field limits
// **************************************************

// Last second and last minute of the count
`define CLK_SEC_MAX 59
`define CLK_MIN_MAX 59

// Last hour of the day
`define CLK_HOUR_MAX 23

// Months run 1 to 12
`define CLK_MONTH_MAX 12

// Years 0 to 99 stand for 2000 to 2099
`define CLK_YEAR_MAX 99

// **************************************************
// Button input
// **************************************************

// Flops in each button synchronizer
`define CLK_SYNC_STAGES 2

`endif

// ==== verilog/clock_pkg.sv ====
package clock_pkg;

	// **************************************************
	// Mode register encoding
	// **************************************************

	// Listed in stepping order, SET_YEAR wraps back to RUN
	typedef enum logic [2:0] {
		RUN       = 3'd0,
		SET_HOUR  = 3'd1,
		SET_MIN   = 3'd2,
		SET_DAY   = 3'd3,
		SET_MONTH = 3'd4,
		SET_YEAR  = 3'd5
	} clock_mode_t;

	// **************************************************
	// Field types
	// **************************************************

	// Time of day
	typedef logic [5:0] sec_t;
	typedef logic [5:0] min_t;
	typedef logic [4:0] hour_t;

	// Day of month, 1 to 31
	typedef logic [4:0] day_t;

	// Month, 1 to 12
	typedef logic [3:0] month_t;

	// Year offset from 2000, 0 to 99
	typedef logic [6:0] year_t;

endpackage

// ==== verilog/clock_top.sv ====
`timescale 1ns/1ps

module clock_top (
	input  logic                   clk_1Hz,
	input  logic                   rst_n,
	input  logic                   set_btn_n,
	input  logic                   mode_btn_n,
	output clock_pkg::clock_mode_t mode,
	output clock_pkg::sec_t        seconds,
	output clock_pkg::min_t        minutes,
	output clock_pkg::hour_t       hours,
	output clock_pkg::day_t        days,
	output clock_pkg::month_t      months,
	output clock_pkg::year_t       years
);

	logic set_press;
	logic mode_press;
	logic day_tick;

	// Button front end
	button_sync u_button_sync (
		.clk_1Hz    (clk_1Hz),
		.rst_n      (rst_n),
		.set_btn_n  (set_btn_n),
		.mode_btn_n (mode_btn_n),
		.set_press  (set_press),
		.mode_press (mode_press)
	);

	mode_ctrl u_mode_ctrl (
		.clk_1Hz    (clk_1Hz),
		.rst_n      (rst_n),
		.mode_press (mode_press),
		.mode       (mode)
	);

	time_counter u_time_counter (
		.clk_1Hz   (clk_1Hz),
		.rst_n     (rst_n),
		.mode      (mode),
		.set_press (set_press),
		.seconds   (seconds),
		.minutes   (minutes),
		.hours     (hours),
		.day_tick  (day_tick)
	);

	// Date advances on the midnight carry
	date_counter u_date_counter (
		.clk_1Hz   (clk_1Hz),
		.rst_n     (rst_n),
		.mode      (mode),
		.set_press (set_press),
		.day_tick  (day_tick),
		.days      (days),
		.months    (months),
		.years     (years)
	);

endmodule

// ==== verilog/date_counter.sv ====
`timescale 1ns/1ps
`include "clock_defines.svh"

module date_counter (
	input  logic                   clk_1Hz,
	input  logic                   rst_n,
	input  clock_pkg::clock_mode_t mode,
	input  logic                   set_press,
	input  logic                   day_tick,
	output clock_pkg::day_t        days,
	output clock_pkg::month_t      months,
	output clock_pkg::year_t       years
);

	import clock_pkg::*;

	localparam month_t MONTH_MAX = month_t'(`CLK_MONTH_MAX);
	localparam year_t  YEAR_MAX  = year_t'(`CLK_YEAR_MAX);

	// **************************************************
	// Calendar rules
	// **************************************************

	// Within 2000 to 2099 every fourth year is a leap year
	function automatic logic is_leap(input year_t y);
		return (y[1:0] == 2'b00);
	endfunction

	function automatic day_t month_len(input month_t m, input year_t y);
		day_t len;
		case (m)
			4'd4, 4'd6, 4'd9, 4'd11: begin
				len = 5'd30;
			end
			4'd2: begin
				len = is_leap(y) ? 5'd29 : 5'd28;
			end
			default: begin
				len = 5'd31;
			end
		endcase
		return len;
	endfunction

	// Pull the day back when the new month or year is shorter
	function automatic day_t clamp_day(input day_t d, input month_t m, input year_t y);
		day_t len;
		len = month_len(m, y);
		return (d > len) ? len : d;
	endfunction

	day_t   cur_len;
	logic   month_end;
	day_t   day_next;
	month_t month_next;
	year_t  year_next;

	assign cur_len    = month_len(months, years);
	assign month_end  = (days == cur_len);
	assign day_next   = month_end ? day_t'(1) : days + 1'b1;
	assign month_next = (months == MONTH_MAX) ? month_t'(1) : months + 1'b1;
	assign year_next  = (years == YEAR_MAX) ? '0 : years + 1'b1;

	// **************************************************
	// Date registers
	// **************************************************

	always_ff @(posedge clk_1Hz or negedge rst_n) begin
		if (!rst_n) begin
			days   <= day_t'(1);
			months <= month_t'(1);
			years  <= '0;
		end else if (day_tick) begin
			days <= day_next;
			if (month_end) begin
				months <= month_next;
				if (months == MONTH_MAX) begin
					years <= year_next;
				end
			end
		end else if (set_press) begin
			case (mode)
				SET_DAY: begin
					days <= day_next;
				end
				SET_MONTH: begin
					months <= month_next;
					days   <= clamp_day(days, month_next, years);
				end
				SET_YEAR: begin
					// Only 29 February can be cut short here
					years <= year_next;
					days  <= clamp_day(days, months, year_next);
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== verilog/mode_ctrl.sv ====
`timescale 1ns/1ps

module mode_ctrl (
	input  logic                   clk_1Hz,
	input  logic                   rst_n,
	input  logic                   mode_press,
	output clock_pkg::clock_mode_t mode
);

	import clock_pkg::*;

	// **************************************************
	// Step order
	// **************************************************

	function automatic clock_mode_t next_mode(input clock_mode_t cur);
		clock_mode_t nxt;
		case (cur)
			RUN: begin
				nxt = SET_HOUR;
			end
			SET_HOUR: begin
				nxt = SET_MIN;
			end
			SET_MIN: begin
				nxt = SET_DAY;
			end
			SET_DAY: begin
				nxt = SET_MONTH;
			end
			SET_MONTH: begin
				nxt = SET_YEAR;
			end
			// SET_YEAR and the unused codes go back to RUN
			default: begin
				nxt = RUN;
			end
		endcase
		return nxt;
	endfunction

	// **************************************************
	// Mode register
	// **************************************************

	// Selects which field a set press acts on
	always_ff @(posedge clk_1Hz or negedge rst_n) begin
		if (!rst_n) begin
			mode <= RUN;
		end else if (mode_press) begin
			mode <= next_mode(mode);
		end
	end

endmodule

// ==== verilog/time_counter.sv ====
`timescale 1ns/1ps
`include "clock_defines.svh"

module time_counter (
	input  logic                   clk_1Hz,
	input  logic                   rst_n,
	input  clock_pkg::clock_mode_t mode,
	input  logic                   set_press,
	output clock_pkg::sec_t        seconds,
	output clock_pkg::min_t        minutes,
	output clock_pkg::hour_t       hours,
	output logic                   day_tick
);

	import clock_pkg::*;

	localparam sec_t  SEC_MAX  = sec_t'(`CLK_SEC_MAX);
	localparam min_t  MIN_MAX  = min_t'(`CLK_MIN_MAX);
	localparam hour_t HOUR_MAX = hour_t'(`CLK_HOUR_MAX);

	logic  sec_last;
	logic  min_last;
	logic  hour_last;
	min_t  min_next;
	hour_t hour_next;

	// **************************************************
	// Wrap detection
	// **************************************************

	assign sec_last  = (seconds == SEC_MAX);
	assign min_last  = (minutes == MIN_MAX);
	assign hour_last = (hours == HOUR_MAX);

	assign min_next  = min_last ? '0 : minutes + 1'b1;
	assign hour_next = hour_last ? '0 : hours + 1'b1;

	// Midnight carry, seen by the date counter on the same edge
	assign day_tick = (mode == RUN) && sec_last && min_last && hour_last;

	// **************************************************
	// Time registers
	// **************************************************

	always_ff @(posedge clk_1Hz or negedge rst_n) begin
		if (!rst_n) begin
			seconds <= '0;
			minutes <= '0;
			hours   <= '0;
		end else begin
			case (mode)
				RUN: begin
					if (sec_last) begin
						seconds <= '0;
						minutes <= min_next;
						if (min_last) begin
							hours <= hour_next;
						end
					end else begin
						seconds <= seconds + 1'b1;
					end
				end
				SET_HOUR: begin
					if (set_press) begin
						hours <= hour_next;
					end
				end
				SET_MIN: begin
					// Setting a minute restarts it from zero seconds
					if (set_press) begin
						minutes <= min_next;
						seconds <= '0;
					end
				end
				// Time is frozen while a date field is being set
				default: begin
				end
			endcase
		end
	end

endmodule
